/* design/ppu_pkg.sv */
package ppu_pkg;

  // Posit format, 8 bits with es = 0
  localparam int POSIT_BITS = 8;
  localparam int TE_BITS = 5;
  localparam int MAX_TE = 6;

  // Mantissa includes the hidden one
  localparam int MANT_SIZE = 6;
  localparam int MAX_TE_DIFF = 12;
  localparam int MANT_ADD_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF + 1;
  localparam int MANT_SUB_RESULT_SIZE = MANT_SIZE + MAX_TE_DIFF;

  // Leading zero count over the aligned difference
  localparam int LZC_BITS = 5;

  // Regime head, fraction and room for the longest regime run
  localparam int ENC_EXT_BITS = 2 + (MANT_SUB_RESULT_SIZE - 1) + (POSIT_BITS - 1);

  localparam logic [POSIT_BITS-1:0] POSIT_ZERO = 8'h00;
  localparam logic [POSIT_BITS-1:0] POSIT_NAR = 8'h80;
  localparam logic [POSIT_BITS-1:0] POSIT_MAXPOS = 8'h7F;
  localparam logic [POSIT_BITS-1:0] POSIT_MINPOS = 8'h01;

  localparam int PIPE_LATENCY = 3;

endpackage : ppu_pkg

/* design/posit_decoder.sv */
`timescale 1ns/1ps

module posit_decoder
  import ppu_pkg::*;
(
  input  logic [POSIT_BITS-1:0] posit_i,
  output logic                  sign_o,
  output logic [   TE_BITS-1:0] te_o,
  output logic [ MANT_SIZE-1:0] mant_o,
  output logic                  is_zero_o,
  output logic                  is_nar_o
);

  logic [POSIT_BITS-1:0] abs_val;
  logic [           3:0] run;
  logic                  done;
  logic [POSIT_BITS-2:0] rem;
  logic [   TE_BITS-1:0] run_ext;

  assign sign_o = posit_i[POSIT_BITS-1];
  assign is_zero_o = (posit_i == POSIT_ZERO);
  assign is_nar_o = (posit_i == POSIT_NAR);

  // Negative words are decoded from their magnitude
  assign abs_val = sign_o ? (~posit_i + 1'b1) : posit_i;

  // Length of the regime run below the sign bit
  always_comb begin
    run = '0;
    done = 1'b0;
    for (int i = POSIT_BITS - 2; i >= 0; i--) begin
      if (!done && (abs_val[i] == abs_val[POSIT_BITS-2])) begin
        run = run + 1'b1;
      end else begin
        done = 1'b1;
      end
    end
  end

  assign run_ext = TE_BITS'(run);

  // Run of ones gives k = run - 1, run of zeros gives k = -run
  assign te_o = abs_val[POSIT_BITS-2] ? (run_ext - 1'b1) : (~run_ext + 1'b1);

  // Drop regime and terminator, fraction ends up left aligned
  assign rem = abs_val[POSIT_BITS-2:0] << (run + 4'd1);

  assign mant_o = {1'b1, rem[POSIT_BITS-2 -: MANT_SIZE-1]};

endmodule : posit_decoder

/* design/operand_sort.sv */
`timescale 1ns/1ps

module operand_sort
  import ppu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  op_sub_i,
  input  logic                  sign_a_i,
  input  logic [   TE_BITS-1:0] te_a_i,
  input  logic [ MANT_SIZE-1:0] mant_a_i,
  input  logic                  is_zero_a_i,
  input  logic                  is_nar_a_i,
  input  logic                  sign_b_i,
  input  logic [   TE_BITS-1:0] te_b_i,
  input  logic [ MANT_SIZE-1:0] mant_b_i,
  input  logic                  is_zero_b_i,
  input  logic                  is_nar_b_i,
  output logic                  valid_o,
  output logic [   TE_BITS-1:0] te1_o,
  output logic [   TE_BITS-1:0] te2_o,
  output logic [ MANT_SIZE-1:0] mant1_o,
  output logic [ MANT_SIZE-1:0] mant2_o,
  output logic                  have_opposite_sign_o,
  output logic                  sign_o,
  output logic                  special_valid_o,
  output logic [POSIT_BITS-1:0] special_posit_o
);

  logic sign_b_eff;
  logic opposite;
  logic same_mag;
  logic a_ge_b;
  logic zero_any;
  logic nar_any;

  // Subtract is an add with b negated
  assign sign_b_eff = sign_b_i ^ op_sub_i;
  assign opposite = sign_a_i ^ sign_b_eff;
  assign same_mag = (te_a_i == te_b_i) && (mant_a_i == mant_b_i);
  assign zero_any = is_zero_a_i | is_zero_b_i;
  assign nar_any = is_nar_a_i | is_nar_b_i;

  // Zero always sorts as the smaller operand
  assign a_ge_b = is_zero_b_i | (!is_zero_a_i &&
                  (($signed(te_a_i) > $signed(te_b_i)) ||
                   ((te_a_i == te_b_i) && (mant_a_i >= mant_b_i))));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    te1_o <= a_ge_b ? te_a_i : te_b_i;
    mant1_o <= a_ge_b ? mant_a_i : mant_b_i;
    // A zero operand adds nothing, so it is aligned with the other one
    te2_o <= zero_any ? (a_ge_b ? te_a_i : te_b_i) : (a_ge_b ? te_b_i : te_a_i);
    mant2_o <= zero_any ? '0 : (a_ge_b ? mant_b_i : mant_a_i);
    have_opposite_sign_o <= opposite;
    sign_o <= a_ge_b ? sign_a_i : sign_b_eff;
    special_valid_o <= nar_any | (is_zero_a_i & is_zero_b_i) |
                       (opposite & same_mag & !zero_any);
    special_posit_o <= nar_any ? POSIT_NAR : POSIT_ZERO;
  end

endmodule : operand_sort

/* design/core_add.sv */
`timescale 1ns/1ps

module core_add
  import ppu_pkg::*;
(
  input  logic [MANT_ADD_RESULT_SIZE-1:0] mant_i,
  input  logic [             TE_BITS-1:0] te_diff_i,
  output logic [MANT_ADD_RESULT_SIZE-1:0] new_mant_o,
  output logic [             TE_BITS-1:0] new_te_diff_o,
  output logic                            frac_truncated_o
);

  logic carry;

  assign carry = mant_i[MANT_ADD_RESULT_SIZE-1];

  // Carry moves the hidden one back down a position
  always_comb begin
    if (carry) begin
      new_mant_o = mant_i >> 1;
      new_te_diff_o = te_diff_i + 1'b1;
      frac_truncated_o = mant_i[0];
    end else begin
      new_mant_o = mant_i;
      new_te_diff_o = te_diff_i;
      frac_truncated_o = 1'b0;
    end
  end

endmodule : core_add

/* design/core_sub.sv */
`timescale 1ns/1ps

module core_sub
  import ppu_pkg::*;
(
  input  logic [MANT_SUB_RESULT_SIZE-1:0] mant_i,
  input  logic [             TE_BITS-1:0] te_diff_i,
  output logic [MANT_SUB_RESULT_SIZE-1:0] new_mant_o,
  output logic [             TE_BITS-1:0] new_te_diff_o
);

  logic [LZC_BITS-1:0] lzc;
  logic                found;

  // Leading zeros above the first set bit
  always_comb begin
    lzc = '0;
    found = 1'b0;
    for (int i = MANT_SUB_RESULT_SIZE - 1; i >= 0; i--) begin
      if (!found) begin
        if (mant_i[i]) begin
          found = 1'b1;
        end else begin
          lzc = lzc + 1'b1;
        end
      end
    end
  end

  // Hidden one returns to the top bit
  assign new_mant_o = mant_i << lzc;

  // Each shift step lowers the exponent by one
  assign new_te_diff_o = te_diff_i - TE_BITS'(lzc);

endmodule : core_sub

/* design/core_add_sub.sv */
`timescale 1ns/1ps

module core_add_sub
  import ppu_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  logic [             TE_BITS-1:0] te1_i,
  input  logic [             TE_BITS-1:0] te2_i,
  input  logic [           MANT_SIZE-1:0] mant1_i,
  input  logic [           MANT_SIZE-1:0] mant2_i,
  input  logic                            have_opposite_sign_i,
  input  logic                            sign_i,
  input  logic                            special_valid_i,
  input  logic [          POSIT_BITS-1:0] special_posit_i,
  output logic                            valid_o,
  output logic [MANT_ADD_RESULT_SIZE-1:0] mant_o,
  output logic [             TE_BITS-1:0] te_o,
  output logic                            frac_truncated_o,
  output logic                            sign_o,
  output logic                            special_valid_o,
  output logic [          POSIT_BITS-1:0] special_posit_o
);

  function automatic logic [MANT_SUB_RESULT_SIZE-1:0] c2(
    input logic [MANT_SUB_RESULT_SIZE-1:0] a
  );
    return ~a + 1'b1;
  endfunction

  logic [             TE_BITS-1:0] te_diff_st0;
  logic [MANT_SUB_RESULT_SIZE-1:0] mant1_upshifted;
  logic [MANT_SUB_RESULT_SIZE-1:0] mant2_upshifted;
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_sum_st0;

  logic [             TE_BITS-1:0] te_diff_st1;
  logic [             TE_BITS-1:0] te2_st1;
  logic [MANT_ADD_RESULT_SIZE-1:0] mant_sum_st1;
  logic                            have_opposite_sign_st1;

  logic [MANT_ADD_RESULT_SIZE-1:0] mant_out_core_add;
  logic [             TE_BITS-1:0] te_diff_out_core_add;
  logic [MANT_SUB_RESULT_SIZE-1:0] mant_out_core_sub;
  logic [             TE_BITS-1:0] te_diff_out_core_sub;
  logic [             TE_BITS-1:0] te_diff_updated;

  // Operands arrive sorted, so the difference is never negative
  assign te_diff_st0 = te1_i - te2_i;

  assign mant1_upshifted = {mant1_i, {MAX_TE_DIFF{1'b0}}};
  assign mant2_upshifted = {mant2_i, {MAX_TE_DIFF{1'b0}}} >> te_diff_st0;

  assign mant_sum_st0 = mant1_upshifted +
                        (have_opposite_sign_i ? c2(mant2_upshifted) : mant2_upshifted);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    te_diff_st1 <= te_diff_st0;
    te2_st1 <= te2_i;
    mant_sum_st1 <= mant_sum_st0;
    have_opposite_sign_st1 <= have_opposite_sign_i;
    sign_o <= sign_i;
    special_valid_o <= special_valid_i;
    special_posit_o <= special_posit_i;
  end

  core_add core_add_i (
    .mant_i           (mant_sum_st1),
    .te_diff_i        (te_diff_st1),
    .new_mant_o       (mant_out_core_add),
    .new_te_diff_o    (te_diff_out_core_add),
    .frac_truncated_o (frac_truncated_o)
  );

  // Borrow out of the top bit is dropped for unlike signs
  core_sub core_sub_i (
    .mant_i        (mant_sum_st1[MANT_SUB_RESULT_SIZE-1:0]),
    .te_diff_i     (te_diff_st1),
    .new_mant_o    (mant_out_core_sub),
    .new_te_diff_o (te_diff_out_core_sub)
  );

  assign te_diff_updated = have_opposite_sign_st1 ? te_diff_out_core_sub : te_diff_out_core_add;
  assign mant_o = have_opposite_sign_st1 ? {1'b0, mant_out_core_sub} : mant_out_core_add;
  assign te_o = te2_st1 + te_diff_updated;

endmodule : core_add_sub

/* design/posit_encoder.sv */
`timescale 1ns/1ps

module posit_encoder
  import ppu_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  logic [MANT_ADD_RESULT_SIZE-1:0] mant_i,
  input  logic [             TE_BITS-1:0] te_i,
  input  logic                            frac_truncated_i,
  input  logic                            sign_i,
  input  logic                            special_valid_i,
  input  logic [          POSIT_BITS-1:0] special_posit_i,
  output logic                            valid_o,
  output logic [          POSIT_BITS-1:0] posit_o
);

  logic                    te_neg;
  logic [     TE_BITS-1:0] shamt;
  logic [ENC_EXT_BITS-1:0] ext;
  logic                    lsb;
  logic                    guard;
  logic                    sticky;
  logic                    round_up;
  logic [  POSIT_BITS-1:0] mag;
  logic [  POSIT_BITS-1:0] posit_next;

  assign te_neg = te_i[TE_BITS-1];

  // Negative te needs -te - 1 extra zeros ahead of the terminating one
  assign shamt = te_neg ? ~te_i : te_i;

  // Regime head is sign extended into the full run
  assign ext = $signed({te_neg ? 2'b01 : 2'b10,
                        mant_i[MANT_SUB_RESULT_SIZE-2:0],
                        {(POSIT_BITS - 1){1'b0}}}) >>> shamt;

  assign lsb = ext[ENC_EXT_BITS-POSIT_BITS+1];
  assign guard = ext[ENC_EXT_BITS-POSIT_BITS];
  assign sticky = (|ext[ENC_EXT_BITS-POSIT_BITS-1:0]) | frac_truncated_i;

  // Round to nearest, ties to even
  assign round_up = guard & (lsb | sticky);

  always_comb begin
    if ($signed(te_i) >= MAX_TE) begin
      mag = POSIT_MAXPOS;
    end else if ($signed(te_i) < -MAX_TE) begin
      // Never rounds to zero
      mag = POSIT_MINPOS;
    end else begin
      mag = {1'b0, ext[ENC_EXT_BITS-1 -: POSIT_BITS-1]} + POSIT_BITS'(round_up);
    end
  end

  always_comb begin
    if (special_valid_i) begin
      posit_next = special_posit_i;
    end else if (sign_i) begin
      posit_next = ~mag + 1'b1;
    end else begin
      posit_next = mag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      posit_o <= POSIT_ZERO;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        posit_o <= posit_next;
      end
    end
  end

endmodule : posit_encoder

/* design/ppu_adder.sv */
`timescale 1ns/1ps

module ppu_adder
  import ppu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  op_sub_i,
  input  logic [POSIT_BITS-1:0] posit_a_i,
  input  logic [POSIT_BITS-1:0] posit_b_i,
  output logic                  valid_o,
  output logic [POSIT_BITS-1:0] posit_o
);

  logic                            a_sign;
  logic [             TE_BITS-1:0] a_te;
  logic [           MANT_SIZE-1:0] a_mant;
  logic                            a_zero;
  logic                            a_nar;
  logic                            b_sign;
  logic [             TE_BITS-1:0] b_te;
  logic [           MANT_SIZE-1:0] b_mant;
  logic                            b_zero;
  logic                            b_nar;

  // Stage 1, sorted operands
  logic                            s1_valid;
  logic [             TE_BITS-1:0] s1_te1;
  logic [             TE_BITS-1:0] s1_te2;
  logic [           MANT_SIZE-1:0] s1_mant1;
  logic [           MANT_SIZE-1:0] s1_mant2;
  logic                            s1_opposite;
  logic                            s1_sign;
  logic                            s1_special_valid;
  logic [          POSIT_BITS-1:0] s1_special_posit;

  // Stage 2, normalized sum
  logic                            s2_valid;
  logic [MANT_ADD_RESULT_SIZE-1:0] s2_mant;
  logic [             TE_BITS-1:0] s2_te;
  logic                            s2_frac_truncated;
  logic                            s2_sign;
  logic                            s2_special_valid;
  logic [          POSIT_BITS-1:0] s2_special_posit;

  posit_decoder posit_decoder_a_i (
    .posit_i   (posit_a_i),
    .sign_o    (a_sign),
    .te_o      (a_te),
    .mant_o    (a_mant),
    .is_zero_o (a_zero),
    .is_nar_o  (a_nar)
  );

  posit_decoder posit_decoder_b_i (
    .posit_i   (posit_b_i),
    .sign_o    (b_sign),
    .te_o      (b_te),
    .mant_o    (b_mant),
    .is_zero_o (b_zero),
    .is_nar_o  (b_nar)
  );

  operand_sort operand_sort_i (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .valid_i              (valid_i),
    .op_sub_i             (op_sub_i),
    .sign_a_i             (a_sign),
    .te_a_i               (a_te),
    .mant_a_i             (a_mant),
    .is_zero_a_i          (a_zero),
    .is_nar_a_i           (a_nar),
    .sign_b_i             (b_sign),
    .te_b_i               (b_te),
    .mant_b_i             (b_mant),
    .is_zero_b_i          (b_zero),
    .is_nar_b_i           (b_nar),
    .valid_o              (s1_valid),
    .te1_o                (s1_te1),
    .te2_o                (s1_te2),
    .mant1_o              (s1_mant1),
    .mant2_o              (s1_mant2),
    .have_opposite_sign_o (s1_opposite),
    .sign_o               (s1_sign),
    .special_valid_o      (s1_special_valid),
    .special_posit_o      (s1_special_posit)
  );

  core_add_sub core_add_sub_i (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .valid_i              (s1_valid),
    .te1_i                (s1_te1),
    .te2_i                (s1_te2),
    .mant1_i              (s1_mant1),
    .mant2_i              (s1_mant2),
    .have_opposite_sign_i (s1_opposite),
    .sign_i               (s1_sign),
    .special_valid_i      (s1_special_valid),
    .special_posit_i      (s1_special_posit),
    .valid_o              (s2_valid),
    .mant_o               (s2_mant),
    .te_o                 (s2_te),
    .frac_truncated_o     (s2_frac_truncated),
    .sign_o               (s2_sign),
    .special_valid_o      (s2_special_valid),
    .special_posit_o      (s2_special_posit)
  );

  posit_encoder posit_encoder_i (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .valid_i          (s2_valid),
    .mant_i           (s2_mant),
    .te_i             (s2_te),
    .frac_truncated_i (s2_frac_truncated),
    .sign_i           (s2_sign),
    .special_valid_i  (s2_special_valid),
    .special_posit_i  (s2_special_posit),
    .valid_o          (valid_o),
    .posit_o          (posit_o)
  );

endmodule : ppu_adder

/* verification/ppu_adder_assert.sv */
`timescale 1ns/1ps

module ppu_adder_assert
  import ppu_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  valid_i,
  input logic [POSIT_BITS-1:0] posit_a_i,
  input logic [POSIT_BITS-1:0] posit_b_i,
  input logic                  valid_o,
  input logic [POSIT_BITS-1:0] posit_o
);

  logic nar_in;

  assign nar_in = valid_i && ((posit_a_i == POSIT_NAR) || (posit_b_i == POSIT_NAR));

  // Pipeline leaves reset empty
  assert property (@(posedge clk_i) rst_i |=> !valid_o)
    else $error("valid_o high in the cycle after reset");

  assert property (@(posedge clk_i) disable iff (rst_i)
                   valid_o == $past(valid_i, PIPE_LATENCY))
    else $error("valid_o does not follow valid_i by %0d cycles", PIPE_LATENCY);

  // NaR operand forces a NaR result
  assert property (@(posedge clk_i) disable iff (rst_i)
                   $past(nar_in, PIPE_LATENCY) |-> (posit_o == POSIT_NAR))
    else $error("NaR operand did not give a NaR result");

endmodule : ppu_adder_assert

bind ppu_adder ppu_adder_assert ppu_adder_assert_i (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .valid_i   (valid_i),
  .posit_a_i (posit_a_i),
  .posit_b_i (posit_b_i),
  .valid_o   (valid_o),
  .posit_o   (posit_o)
);

/* verification/ppu_adder_tb.sv */
`timescale 1ns/1ps

module ppu_adder_tb
  import ppu_pkg::*;
();

  localparam string VEC_FILE = "verification/ppu_adder_input.txt";

  logic                    clk_i;
  logic                    rst_i;
  logic                    valid_i;
  logic                    op_sub_i;
  logic [  POSIT_BITS-1:0] posit_a_i;
  logic [  POSIT_BITS-1:0] posit_b_i;
  logic                    valid_o;
  logic [  POSIT_BITS-1:0] posit_o;

  // Vectors as read from the data file
  logic                    vec_op[$];
  logic [  POSIT_BITS-1:0] vec_a[$];
  logic [  POSIT_BITS-1:0] vec_b[$];
  logic [  POSIT_BITS-1:0] vec_exp[$];

  logic [  POSIT_BITS-1:0] exp_q[$];
  logic [PIPE_LATENCY-1:0] strobe_hist;
  int                      seed = 32'h0647_94c2;
  int                      cycle_count = 0;
  int                      cycle_limit = 0;
  int                      checked = 0;

  ppu_adder ppu_adder_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (valid_i),
    .op_sub_i  (op_sub_i),
    .posit_a_i (posit_a_i),
    .posit_b_i (posit_b_i),
    .valid_o   (valid_o),
    .posit_o   (posit_o)
  );

  task automatic stop_on_error();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_posit(input logic [POSIT_BITS-1:0] actual,
                             input logic [POSIT_BITS-1:0] expected);
    if (actual !== expected) begin
      $display("FAIL posit_o: got %h, expected %h (result %0d)", actual, expected, checked);
      stop_on_error();
    end
  endtask

  task automatic check_valid(input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL valid_o: got %h, expected %h (cycle %0d)", actual, expected, cycle_count);
      stop_on_error();
    end
  endtask

  task automatic load_vectors();
    int                    fd;
    int                    count;
    string                 line;
    logic [           7:0] f_op;
    logic [POSIT_BITS-1:0] f_a;
    logic [POSIT_BITS-1:0] f_b;
    logic [POSIT_BITS-1:0] f_exp;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
      stop_on_error();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          count = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp);
          if (count != 4) begin
            $display("Vector line could not be parsed: %s", line);
            stop_on_error();
          end else begin
            vec_op.push_back(f_op[0]);
            vec_a.push_back(f_a);
            vec_b.push_back(f_b);
            vec_exp.push_back(f_exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // Strobes as the DUT sampled them
  always @(posedge clk_i) begin
    if (rst_i) begin
      strobe_hist <= '0;
    end else begin
      strobe_hist <= {strobe_hist[PIPE_LATENCY-2:0], valid_i};
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d results still pending",
               cycle_count, exp_q.size());
      stop_on_error();
    end
  end

  // Outputs are stable at the falling edge, valid_o is known from the first edge
  always @(negedge clk_i) begin
    if (cycle_count > 0) begin
      check_valid(valid_o, strobe_hist[PIPE_LATENCY-1]);
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("valid_o was high with no operation outstanding");
          stop_on_error();
        end else begin
          check_posit(posit_o, exp_q.pop_front());
          checked++;
        end
      end
    end
  end

  initial begin
    int gap;
    rst_i = 1'b1;
    valid_i = 1'b0;
    op_sub_i = 1'b0;
    posit_a_i = '0;
    posit_b_i = '0;
    load_vectors();
    cycle_limit = 4 * vec_a.size() + 50;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < vec_a.size(); i++) begin
      @(negedge clk_i);
      valid_i = 1'b1;
      op_sub_i = vec_op[i];
      posit_a_i = vec_a[i];
      posit_b_i = vec_b[i];
      exp_q.push_back(vec_exp[i]);
      // Every other block of eight runs back to back
      if ((i / 8) % 2 == 1) begin
        gap = 0;
      end else begin
        gap = $unsigned($random(seed)) % 3;
      end
      repeat (gap) begin
        @(negedge clk_i);
        valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (PIPE_LATENCY) @(negedge clk_i);
    $display("%0d results checked", checked);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : ppu_adder_tb

/* verification/ppu_adder_input.txt */
# Posit8 es=0 adder vectors, all fields hex
# Columns: op (0 add, 1 sub), operand a, operand b, expected result
# Like signs, te difference 0 to 12
0 40 40 60
0 60 40 68
0 70 50 73
0 78 40 78
0 7C 40 7C
0 72 0C 72
0 70 04 70
0 78 04 78
0 7C 04 7C
0 7C 02 7C
0 7E 02 7E
0 7E 01 7E
0 7F 01 7F
# Like signs with carry, negative operands
0 48 50 66
0 6C 50 72
0 7D 7A 7E
0 C0 C0 A0
0 B0 C0 9C
0 61 41 69
# Unlike signs, leading zero normalization
1 50 40 20
1 41 40 02
0 60 C0 40
1 40 60 C0
1 7F 40 7F
1 70 02 70
1 28 40 E8
1 40 C0 60
0 79 BF 78
# Round to nearest even, ties and sticky
0 78 44 79
0 79 40 7A
0 5F 5F 70
1 64 04 64
# Saturation
0 7F 7F 7F
1 03 02 01
# NaR, zero operands, exact cancellation
0 80 40 80
1 40 80 80
0 55 00 55
1 00 55 AB
1 00 B8 48
1 37 37 00
0 00 00 00
0 A3 5D 00

/* ppu_adder.f */
design/ppu_pkg.sv
design/posit_decoder.sv
design/operand_sort.sv
design/core_add.sv
design/core_sub.sv
design/core_add_sub.sv
design/posit_encoder.sv
design/ppu_adder.sv
verification/ppu_adder_assert.sv
verification/ppu_adder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the posit adder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f ppu_adder.f \
  --top-module ppu_adder_tb -o ppu_adder_sim

./obj_dir/ppu_adder_sim 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
